// File: flist.f
logic/ipod_pkg.sv
logic/speed_regs.sv
logic/sample_tick_gen.sv
logic/transport_regs.sv
logic/flash_player.sv
logic/ipod_top.sv
verification/flash_model.sv
verification/ipod_checker.sv
verification/tb_ipod.sv

// File: logic/flash_player.sv
`timescale 1ns/1ps

module flash_player
  import ipod_pkg::*;
#(
  parameter flash_addr_t LAST_ADDR = 23'h7FFFF
)
(
  input  logic          CLK_50M,
  input  logic          arst_n,
  input  logic          tick,
  input  transport_t    ctrl,
  output flash_req_t    flash_req,
  input  flash_rsp_t    flash_rsp,
  output audio_sample_t sample,
  output logic          sample_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_await,
    st_emit
  } state_t;

  state_t      state;
  flash_addr_t next_addr;
  logic        next_half;    // 1 selects the upper 16 bits
  flash_addr_t req_addr;
  flash_word_t held_word;
  logic        word_valid;   // held_word belongs to next_addr
  logic        pend_tick;
  logic        discard;

  flash_addr_t adv_addr;
  logic        adv_same;
  flash_addr_t start_addr;
  logic        start_half;
  logic        go;
  logic        drop;

  function automatic audio_sample_t upper_byte(flash_word_t w, logic hi);
    return hi ? w[31:24] : w[15:8];
  endfunction

  // ============================================================
  // Position stepping
  // ============================================================
  // Half always toggles and the word moves when leaving its last half
  always_comb
  begin
    adv_addr = next_addr;
    adv_same = 1'b1;
    if (ctrl.forward && next_half)
    begin
      adv_same = 1'b0;
      adv_addr = (next_addr == LAST_ADDR) ? '0 : next_addr + 1'b1;
    end
    else if (!ctrl.forward && !next_half)
    begin
      adv_same = 1'b0;
      adv_addr = (next_addr == '0) ? LAST_ADDR : next_addr - 1'b1;
    end
  end

  assign start_addr = ctrl.forward ? '0 : LAST_ADDR;
  assign start_half = ~ctrl.forward;

  assign go   = (tick || pend_tick) && ctrl.play && !ctrl.restart;
  assign drop = discard || ctrl.restart;

  assign flash_req.read    = (state == st_request);
  assign flash_req.address = req_addr;
  assign sample_valid      = (state == st_emit);

  // ============================================================
  // Player FSM
  // ============================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= st_idle;
      next_addr  <= '0;
      next_half  <= 1'b0;
      req_addr   <= '0;
      word_valid <= 1'b0;
      pend_tick  <= 1'b0;
      discard    <= 1'b0;
      sample     <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (go)
          begin
            pend_tick <= 1'b0;
            if (word_valid)
            begin
              // Second half already on hand
              sample     <= upper_byte(held_word, next_half);
              next_addr  <= adv_addr;
              next_half  <= ~next_half;
              word_valid <= adv_same;
              state      <= st_emit;
            end
            else
            begin
              req_addr <= next_addr;
              state    <= st_request;
            end
          end
          else
          begin
            // Keep a tick across restart and drop it while paused
            pend_tick <= ctrl.play && (tick || pend_tick);
          end
        end

        st_request:
        begin
          pend_tick <= pend_tick || tick;
          if (!flash_rsp.waitrequest)
          begin
            state <= st_await;
          end
        end

        st_await:
        begin
          pend_tick <= pend_tick || tick;
          if (flash_rsp.readdatavalid)
          begin
            if (drop)
            begin
              // Drop the stale word and fetch again from the new position
              pend_tick <= 1'b1;
              state     <= st_idle;
            end
            else
            begin
              sample     <= upper_byte(flash_rsp.readdata, next_half);
              next_addr  <= adv_addr;
              next_half  <= ~next_half;
              word_valid <= adv_same;
              state      <= st_emit;
            end
          end
        end

        st_emit:
        begin
          pend_tick <= pend_tick || tick;
          state     <= st_idle;
        end

        default:
        begin
          state <= st_idle;
        end
      endcase

      // Restart overrides any stepping above
      if (ctrl.restart)
      begin
        next_addr  <= start_addr;
        next_half  <= start_half;
        word_valid <= 1'b0;
      end

      // Mark a read in flight as stale
      if (state == st_await && flash_rsp.readdatavalid)
      begin
        discard <= 1'b0;
      end
      else if (ctrl.restart && (state == st_request || state == st_await))
      begin
        discard <= 1'b1;
      end
    end
  end

  // Last word returned by the flash
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_await && flash_rsp.readdatavalid)
    begin
      held_word <= flash_rsp.readdata;
    end
  end

endmodule

// File: logic/ipod_pkg.sv
package ipod_pkg;

  // ============================================================
  // Widths
  // ============================================================
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [7:0]  audio_sample_t;
  typedef logic [15:0] div_t;

  // Read port toward the flash, driven by the player
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Response from the flash
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // One-cycle speed strobes
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_cmd_t;

  // Player control with a one-cycle restart pulse
  typedef struct packed {
    logic play;
    logic forward;
    logic restart;
  } transport_t;

  // ============================================================
  // ASCII key codes
  // ============================================================
  localparam logic [7:0] key_play     = 8'h45;  // E
  localparam logic [7:0] key_pause    = 8'h44;  // D
  localparam logic [7:0] key_forward  = 8'h46;  // F
  localparam logic [7:0] key_backward = 8'h42;  // B
  localparam logic [7:0] key_restart  = 8'h52;  // R

endpackage

// File: logic/ipod_top.sv
`timescale 1ns/1ps

module ipod_top
  import ipod_pkg::*;
#(
  parameter div_t        DEFAULT_DIV = 16'd1135,
  parameter div_t        SPEED_STEP  = 16'd100,
  parameter div_t        MIN_DIV     = 16'd200,
  parameter div_t        MAX_DIV     = 16'd5000,
  parameter flash_addr_t LAST_ADDR   = 23'h7FFFF
)
(
  input  logic          CLK_50M,
  input  logic          arst_n,
  input  logic [7:0]    key_ascii,
  input  logic          key_valid,
  input  speed_cmd_t    speed_cmd,
  output flash_req_t    flash_req,
  input  flash_rsp_t    flash_rsp,
  output audio_sample_t sample,
  output logic          sample_valid,
  output div_t          divisor
);

  logic       tick;
  transport_t ctrl;

  // ============================================================
  // Sample rate
  // ============================================================
  speed_regs #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV)
  ) u_speed_regs (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .speed_cmd (speed_cmd),
    .divisor   (divisor)
  );

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .divisor (divisor),
    .tick    (tick)
  );

  // ============================================================
  // Key control and playback
  // ============================================================
  transport_regs u_transport_regs (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key_ascii (key_ascii),
    .key_valid (key_valid),
    .ctrl      (ctrl)
  );

  flash_player #(
    .LAST_ADDR (LAST_ADDR)
  ) u_flash_player (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tick         (tick),
    .ctrl         (ctrl),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

// File: logic/sample_tick_gen.sv
`timescale 1ns/1ps

module sample_tick_gen
  import ipod_pkg::*;
(
  input  logic CLK_50M,
  input  logic arst_n,
  input  div_t divisor,
  output logic tick
);

  div_t count;

  // Wrap when the count reaches the live divisor
  // A lowered divisor below the count wraps at once
  assign tick = (count >= divisor);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= '0;
    end
    else if (tick)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: logic/speed_regs.sv
`timescale 1ns/1ps

module speed_regs
  import ipod_pkg::*;
#(
  parameter div_t DEFAULT_DIV = 16'd1135,
  parameter div_t SPEED_STEP  = 16'd100,
  parameter div_t MIN_DIV     = 16'd200,
  parameter div_t MAX_DIV     = 16'd5000
)
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  speed_cmd_t speed_cmd,
  output div_t       divisor
);

  int   dn_raw;
  int   up_raw;
  div_t faster;
  div_t slower;

  // Next divisor one step either way, clamped to the range
  always_comb
  begin
    dn_raw = int'(divisor) - int'(SPEED_STEP);
    up_raw = int'(divisor) + int'(SPEED_STEP);
    faster = (dn_raw < int'(MIN_DIV)) ? MIN_DIV : div_t'(dn_raw);
    slower = (up_raw > int'(MAX_DIV)) ? MAX_DIV : div_t'(up_raw);
  end

  // Reset strobe first, then up, then down
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      divisor <= DEFAULT_DIV;
    end
    else if (speed_cmd.reset)
    begin
      divisor <= DEFAULT_DIV;
    end
    else if (speed_cmd.up)
    begin
      divisor <= faster;
    end
    else if (speed_cmd.down)
    begin
      divisor <= slower;
    end
  end

endmodule

// File: logic/transport_regs.sv
`timescale 1ns/1ps

module transport_regs
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [7:0] key_ascii,
  input  logic       key_valid,
  output transport_t ctrl
);

  logic hit_play;
  logic hit_pause;
  logic hit_forward;
  logic hit_backward;
  logic hit_restart;

  // ============================================================
  // Key decode
  // ============================================================
  always_comb
  begin
    hit_play     = key_valid && (key_ascii == key_play);
    hit_pause    = key_valid && (key_ascii == key_pause);
    hit_forward  = key_valid && (key_ascii == key_forward);
    hit_backward = key_valid && (key_ascii == key_backward);
    hit_restart  = key_valid && (key_ascii == key_restart);
  end

  // ============================================================
  // Play and direction levels, restart pulse
  // ============================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl.play    <= 1'b0;
      ctrl.forward <= 1'b1;
      ctrl.restart <= 1'b0;
    end
    else
    begin
      if (hit_play)
      begin
        ctrl.play <= 1'b1;
      end
      else if (hit_pause)
      begin
        ctrl.play <= 1'b0;
      end

      if (hit_forward)
      begin
        ctrl.forward <= 1'b1;
      end
      else if (hit_backward)
      begin
        ctrl.forward <= 1'b0;
      end

      // High for one cycle only
      ctrl.restart <= hit_restart;
    end
  end

endmodule

// File: verification/flash_model.sv
`timescale 1ns/1ps

module flash_model
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  flash_req_t  flash_req,
  output flash_rsp_t  flash_rsp,
  output flash_addr_t lookup_addr,
  input  flash_word_t lookup_data
);

  logic [1:0]  wait_cnt;
  logic [2:0]  lat_cnt;
  logic        rdv;
  flash_word_t rdata;

  assign flash_rsp = '{waitrequest: (wait_cnt != 2'd0), readdatavalid: rdv, readdata: rdata};

  // Stall 0 to 3 cycles, then return the word 1 to 4 cycles after acceptance
  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_cnt    <= 2'd0;
      lat_cnt     <= 3'd0;
      rdv         <= 1'b0;
      rdata       <= '0;
      lookup_addr <= '0;
    end
    else
    begin
      rdv <= 1'b0;
      if (lat_cnt != 3'd0)
      begin
        lat_cnt <= lat_cnt - 3'd1;
        if (lat_cnt == 3'd1)
        begin
          rdv   <= 1'b1;
          rdata <= lookup_data;
        end
      end
      if (flash_req.read)
      begin
        if (wait_cnt != 2'd0)
        begin
          wait_cnt <= wait_cnt - 2'd1;
        end
        else
        begin
          lookup_addr <= flash_req.address;
          lat_cnt     <= 3'(1 + ($urandom % 4));
          wait_cnt    <= 2'($urandom % 4);
        end
      end
    end
  end

endmodule

// File: verification/ipod_checker.sv
`timescale 1ns/1ps

module ipod_checker
  import ipod_pkg::*;
#(
  parameter bit   CHECK_FLASH = 1'b1,
  parameter bit   CHECK_DIV   = 1'b1,
  parameter div_t MIN_DIV     = 16'd0,
  parameter div_t MAX_DIV     = 16'hFFFF
)
(
  input logic       CLK_50M,
  input logic       arst_n,
  input flash_req_t flash_req,
  input flash_rsp_t flash_rsp,
  input div_t       divisor
);

  int   fail_count = 0;
  logic outstanding;

  // One word in flight from acceptance until its data returns
  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      outstanding <= 1'b0;
    else if (flash_req.read && !flash_rsp.waitrequest)
      outstanding <= 1'b1;
    else if (flash_rsp.readdatavalid)
      outstanding <= 1'b0;
  end

  // ============================================================
  // Flash read port
  // ============================================================
  if (CHECK_FLASH)
  begin : g_flash
    req_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
      (flash_req.read && flash_rsp.waitrequest) |=>
        (flash_req.read && $stable(flash_req.address)))
    else
    begin
      $error("read or address changed while waitrequest was high");
      fail_count++;
    end

    one_outstanding: assert property (@(posedge CLK_50M) disable iff (!arst_n)
      flash_req.read |-> !outstanding)
    else
    begin
      $error("read issued while a word was still outstanding");
      fail_count++;
    end
  end

  // ============================================================
  // Divisor range
  // ============================================================
  if (CHECK_DIV)
  begin : g_div
    div_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
      (divisor >= MIN_DIV) && (divisor <= MAX_DIV))
    else
    begin
      $error("divisor left its clamped range");
      fail_count++;
    end
  end

endmodule

bind flash_player ipod_checker #(
  .CHECK_DIV (1'b0)
) u_flash_chk (
  .CLK_50M   (CLK_50M),
  .arst_n    (arst_n),
  .flash_req (flash_req),
  .flash_rsp (flash_rsp),
  .divisor   ('0)
);

bind speed_regs ipod_checker #(
  .CHECK_FLASH (1'b0),
  .MIN_DIV     (MIN_DIV),
  .MAX_DIV     (MAX_DIV)
) u_div_chk (
  .CLK_50M   (CLK_50M),
  .arst_n    (arst_n),
  .flash_req ('0),
  .flash_rsp ('0),
  .divisor   (divisor)
);

// File: verification/tb_ipod.sv
`timescale 1ns/1ps

module tb_ipod
  import ipod_pkg::*;
();

  localparam int          DEFAULT_DIV = 20;
  localparam int          SPEED_STEP  = 4;
  localparam int          MIN_DIV     = 8;
  localparam int          MAX_DIV     = 40;
  localparam flash_addr_t LAST_ADDR   = 23'd15;

  // Samples awaited per test
  localparam int N_FWD     = 40;
  localparam int N_BWD     = 40;
  localparam int N_RESUME  = 10;
  localparam int N_SPACING = 12;
  localparam int N_UNKNOWN = 10;
  localparam int WATCHDOG_CYCLES =
    (N_FWD + N_BWD + N_RESUME + N_SPACING + N_UNKNOWN) * (MAX_DIV + 1) * 2;
  localparam int DRAIN_CYCLES = 32;

  localparam speed_cmd_t cmd_up    = '{up: 1'b1, down: 1'b0, reset: 1'b0};
  localparam speed_cmd_t cmd_down  = '{up: 1'b0, down: 1'b1, reset: 1'b0};
  localparam speed_cmd_t cmd_reset = '{up: 1'b0, down: 1'b0, reset: 1'b1};

  logic          CLK_50M;
  logic          arst_n;
  logic [7:0]    key_ascii;
  logic          key_valid;
  speed_cmd_t    speed_cmd;
  flash_req_t    flash_req;
  flash_rsp_t    flash_rsp;
  audio_sample_t sample;
  logic          sample_valid;
  div_t          divisor;
  flash_addr_t   lookup_addr;
  flash_word_t   lookup_data;

  // Expected playback position
  flash_addr_t exp_addr;
  logic        exp_half;
  logic        exp_fwd;
  int          exp_div;

  int sample_count;
  int tick_count;
  int held_count;
  int held_cycle;
  int cycle;
  int checks = 0;
  int errors = 0;
  int test_err_base = 0;

  ipod_top #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV),
    .LAST_ADDR   (LAST_ADDR)
  ) uut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .key_ascii    (key_ascii),
    .key_valid    (key_valid),
    .speed_cmd    (speed_cmd),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .divisor      (divisor)
  );

  flash_model u_flash (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .flash_req   (flash_req),
    .flash_rsp   (flash_rsp),
    .lookup_addr (lookup_addr),
    .lookup_data (lookup_data)
  );

  initial
    CLK_50M = 1'b0;

  always #10 CLK_50M = ~CLK_50M;

  // ============================================================
  // Flash contents and reference model
  // ============================================================
  function automatic flash_word_t word_at(flash_addr_t a);
    flash_word_t x;
    x = {9'd0, a} * 32'h9E37_79B1;
    return x ^ {a[7:0], a, 1'b1};
  endfunction

  assign lookup_data = word_at(lookup_addr);

  // Upper byte of the selected 16-bit half
  function automatic audio_sample_t ref_sample(flash_addr_t a, logic half);
    flash_word_t w;
    w = word_at(a);
    return half ? w[31:24] : w[15:8];
  endfunction

  function automatic flash_addr_t step_addr(flash_addr_t a, logic half, logic fwd);
    if (fwd && half)
      return (a == LAST_ADDR) ? '0 : a + 23'd1;
    if (!fwd && !half)
      return (a == '0) ? LAST_ADDR : a - 23'd1;
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Compare every sample against the model, which follows the key inputs
  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      exp_addr     <= '0;
      exp_half     <= 1'b0;
      exp_fwd      <= 1'b1;
      sample_count <= 0;
      tick_count   <= 0;
      held_count   <= 0;
      held_cycle   <= 0;
      cycle        <= 0;
    end
    else
    begin
      cycle <= cycle + 1;
      if (uut.tick)
        tick_count <= tick_count + 1;
      if (sample_valid)
      begin
        check_value("sample", sample, ref_sample(exp_addr, exp_half));
        sample_count <= sample_count + 1;
        // Second half of a word comes from the held word
        if (exp_half == exp_fwd)
        begin
          held_count <= held_count + 1;
          held_cycle <= cycle;
        end
        exp_addr <= step_addr(exp_addr, exp_half, exp_fwd);
        exp_half <= ~exp_half;
      end
      if (key_valid && key_ascii == key_forward)
        exp_fwd <= 1'b1;
      else if (key_valid && key_ascii == key_backward)
        exp_fwd <= 1'b0;
      else if (key_valid && key_ascii == key_restart)
      begin
        exp_addr <= exp_fwd ? '0 : LAST_ADDR;
        exp_half <= ~exp_fwd;
      end
    end
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic press_key(input logic [7:0] code);
    @(posedge CLK_50M);
    key_ascii <= code;
    key_valid <= 1'b1;
    @(posedge CLK_50M);
    key_valid <= 1'b0;
  endtask

  task automatic speed_strobe(input speed_cmd_t cmd);
    @(posedge CLK_50M);
    speed_cmd <= cmd;
    @(posedge CLK_50M);
    speed_cmd <= '0;
    @(posedge CLK_50M);
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = sample_count + n;
    while (sample_count < target)
      @(posedge CLK_50M);
  endtask

  // Cycles spanned by 10 samples as timed between held halves
  task automatic measure_spacing(output int span);
    int start;
    int t0;
    start = held_count;
    while (held_count == start)
      @(posedge CLK_50M);
    t0    = held_cycle;
    start = held_count;
    while (held_count < start + 5)
      @(posedge CLK_50M);
    span = held_cycle - t0;
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %-22s %0d errors", num, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial
  begin
    int base;
    int span;
    int fails;

    void'($urandom(32'h7dfb));
    arst_n    = 1'b0;
    key_ascii = '0;
    key_valid = 1'b0;
    speed_cmd = '0;
    repeat (16) @(posedge CLK_50M);
    arst_n <= 1'b1;
    @(posedge CLK_50M);

    check_value("divisor", divisor, DEFAULT_DIV);
    repeat (5 * (DEFAULT_DIV + 1)) @(posedge CLK_50M);
    check_value("sample_valid count", sample_count, 0);
    check_value("tick count ok", tick_count >= 4, 1);
    report_test(1, "reset and paused");

    press_key(key_play);
    wait_samples(N_FWD);
    report_test(2, "forward playback");

    press_key(key_pause);
    repeat (DRAIN_CYCLES) @(posedge CLK_50M);
    press_key(key_backward);
    press_key(key_restart);
    press_key(key_play);
    wait_samples(N_BWD);
    report_test(3, "backward restart");

    press_key(key_pause);
    repeat (DRAIN_CYCLES) @(posedge CLK_50M);
    base = sample_count;
    repeat (4 * (DEFAULT_DIV + 1)) @(posedge CLK_50M);
    check_value("sample_valid count", sample_count - base, 0);
    press_key(key_play);
    wait_samples(N_RESUME);
    report_test(4, "pause and resume");

    // Step and clamp both ways, then back to the default
    exp_div = DEFAULT_DIV;
    repeat (6)
    begin
      exp_div = (exp_div - SPEED_STEP < MIN_DIV) ? MIN_DIV : exp_div - SPEED_STEP;
      speed_strobe(cmd_up);
      check_value("divisor", divisor, exp_div);
    end
    repeat (10)
    begin
      exp_div = (exp_div + SPEED_STEP > MAX_DIV) ? MAX_DIV : exp_div + SPEED_STEP;
      speed_strobe(cmd_down);
      check_value("divisor", divisor, exp_div);
    end
    exp_div = DEFAULT_DIV;
    speed_strobe(cmd_reset);
    check_value("divisor", divisor, exp_div);
    measure_spacing(span);
    check_value("sample spacing ok", span >= 10 * (exp_div + 1), 1);
    report_test(5, "speed control");

    // Lower case and other codes outside the key set
    press_key(8'h41);
    press_key(8'h65);
    press_key(8'h64);
    press_key(8'h5A);
    press_key(8'h00);
    check_value("divisor", divisor, exp_div);
    wait_samples(N_UNKNOWN);
    report_test(6, "unknown keys");

    fails = errors + uut.u_flash_player.u_flash_chk.fail_count
          + uut.u_speed_regs.u_div_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             fails - errors);
    if (fails == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    $display("run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule
